//--- Bender.yml
package:
  name: mem_interface

sources:
  - common/mem_map_pkg.sv
  - source/mem_map_decoder.sv
  - source/text_write_ctrl.sv
  - loader/loader_mem.sv
  - keyboard/ps2_receiver.sv
  - keyboard/keycode_fifo.sv
  - source/mem_interface_top.sv
  - target: test
    files:
      - tests/mem_interface_tb.sv

//--- common/mem_map_pkg.sv
package mem_map_pkg;

    //////////////////////////////////////////////////
    // bus widths
    //////////////////////////////////////////////////

    // word address from the pipeline, byte offset already dropped
    localparam int ADDR_W = 30;
    localparam int DATA_W = 32;

    //////////////////////////////////////////////////
    // address map
    //////////////////////////////////////////////////

    // region field of the word address
    localparam int REGION_MSB = 29;
    localparam int REGION_LSB = 26;

    // tag field inside region d
    localparam int TAG_MSB = 25;
    localparam int TAG_LSB = 18;

    // any code not listed here is main memory
    typedef enum logic [3:0] {
        REGION_FLASH  = 4'hB,
        REGION_VMEM   = 4'hC,
        REGION_TIMER  = 4'hD,
        REGION_KBD    = 4'hE,
        REGION_LOADER = 4'hF
    } region_e;

    // region d accesses with this tag hold the pipeline
    localparam logic [7:0] TRAP_TAG = 8'hDD;

    //////////////////////////////////////////////////
    // default sizes
    //////////////////////////////////////////////////

    // 8k words of loader ram
    localparam int LOADER_ADDR_W_DEF = 13;
    // 32 KB of text memory
    localparam int TEXT_ADDR_W_DEF = 15;
    // cycles the text write strobe stays up, minus one
    localparam int TEXT_WAIT_DEF = 5;
    // 8 keycodes
    localparam int KBD_DEPTH_LOG2_DEF = 3;

endpackage

//--- keyboard/keycode_fifo.sv
`timescale 1ns/1ps

module keycode_fifo #(
    parameter int KBD_DEPTH_LOG2 = 3
) (
    input  logic       clk_pipeline,
    input  logic       rst,
    input  logic       push,
    input  logic [7:0] push_code,
    input  logic       pop,
    output logic [7:0] head_code,
    output logic       ready,
    output logic       overflow
);

    localparam int DEPTH = 2 ** KBD_DEPTH_LOG2;

    logic [7:0]              codes [DEPTH];
    logic [KBD_DEPTH_LOG2-1:0] wr_ptr;
    logic [KBD_DEPTH_LOG2-1:0] rd_ptr;
    logic [KBD_DEPTH_LOG2:0]   count;
    logic                      full;
    logic                      do_push;
    logic                      do_pop;

    assign ready   = (count != '0);
    assign full    = (count == (KBD_DEPTH_LOG2 + 1)'(DEPTH));
    // a key arriving while full is lost
    assign do_push = push & ~full;
    assign do_pop  = pop & ready;

    always_ff @(posedge clk_pipeline) begin
        if (do_push) begin
            codes[wr_ptr] <= push_code;
        end
    end

    //////////////////////////////////////////////////
    // pointers, count and overflow flag
    //////////////////////////////////////////////////

    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && full) begin
                overflow <= 1'b1;
            end else if (do_pop) begin
                overflow <= 1'b0;
            end
        end
    end

    assign head_code = codes[rd_ptr];

endmodule

//--- keyboard/ps2_receiver.sv
`timescale 1ns/1ps

module ps2_receiver (
    input  logic       clk_pipeline,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       code_valid,
    output logic [7:0] code
);

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        PARITY,
        STOP
    } ps2_state_e;

    ps2_state_e state;
    logic [2:0] clk_sync;
    logic [2:0] data_sync;
    logic       fall_edge;
    logic       bit_in;
    logic [2:0] bit_cnt;
    logic       start_ok;
    logic       parity_bit;
    logic [7:0] shift_reg;

    // both lines idle high
    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            clk_sync  <= 3'b111;
            data_sync <= 3'b111;
        end else begin
            clk_sync  <= {clk_sync[1:0], ps2_clk};
            data_sync <= {data_sync[1:0], ps2_data};
        end
    end

    // device changes data on rising edge, we sample on falling
    assign fall_edge = clk_sync[2] & ~clk_sync[1];
    assign bit_in    = data_sync[2];

    //////////////////////////////////////////////////
    // frame assembly
    //////////////////////////////////////////////////

    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            state      <= IDLE;
            bit_cnt    <= 3'd0;
            start_ok   <= 1'b0;
            parity_bit <= 1'b0;
            code_valid <= 1'b0;
        end else begin
            code_valid <= 1'b0;
            if (fall_edge) begin
                case (state)
                    IDLE: begin
                        start_ok <= ~bit_in;
                        bit_cnt  <= 3'd0;
                        state    <= DATA;
                    end
                    DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= PARITY;
                        end
                    end
                    PARITY: begin
                        parity_bit <= bit_in;
                        state      <= STOP;
                    end
                    STOP: begin
                        // odd parity over data plus parity bit
                        code_valid <= start_ok & bit_in & (^shift_reg ^ parity_bit);
                        state      <= IDLE;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // lsb arrives first
    always_ff @(posedge clk_pipeline) begin
        if (fall_edge && state == DATA) begin
            shift_reg <= {bit_in, shift_reg[7:1]};
        end
    end

    assign code = shift_reg;

endmodule

//--- list.f
common/mem_map_pkg.sv
source/mem_map_decoder.sv
source/text_write_ctrl.sv
loader/loader_mem.sv
keyboard/ps2_receiver.sv
keyboard/keycode_fifo.sv
source/mem_interface_top.sv
tests/mem_interface_tb.sv

//--- loader/loader_mem.sv
`timescale 1ns/1ps

module loader_mem #(
    parameter int LOADER_ADDR_W = mem_map_pkg::LOADER_ADDR_W_DEF
) (
    input  logic                           clk_pipeline,
    input  logic [LOADER_ADDR_W-1:0]       data_addr,
    input  logic [mem_map_pkg::DATA_W-1:0] data_in,
    input  logic [3:0]                     wen,
    input  logic [LOADER_ADDR_W-1:0]       instr_addr,
    output logic [mem_map_pkg::DATA_W-1:0] data_out,
    output logic [mem_map_pkg::DATA_W-1:0] instr_out
);

    import mem_map_pkg::*;

    localparam int DEPTH = 2 ** LOADER_ADDR_W;
    localparam int LANES = DATA_W / 8;

    logic [DATA_W-1:0] mem [DEPTH];

    //////////////////////////////////////////////////
    // data port, byte writes and registered read
    //////////////////////////////////////////////////

    always_ff @(posedge clk_pipeline) begin
        for (int lane = 0; lane < LANES; lane++) begin
            if (wen[lane]) begin
                mem[data_addr][lane*8 +: 8] <= data_in[lane*8 +: 8];
            end
        end
        // old word on a read during write
        data_out <= mem[data_addr];
    end

    //////////////////////////////////////////////////
    // instruction port, read only
    //////////////////////////////////////////////////

    always_ff @(posedge clk_pipeline) begin
        instr_out <= mem[instr_addr];
    end

endmodule

//--- source/mem_interface_top.sv
`timescale 1ns/1ps

module mem_interface_top #(
    parameter int LOADER_ADDR_W  = mem_map_pkg::LOADER_ADDR_W_DEF,
    parameter int TEXT_ADDR_W    = mem_map_pkg::TEXT_ADDR_W_DEF,
    parameter int TEXT_WAIT      = mem_map_pkg::TEXT_WAIT_DEF,
    parameter int KBD_DEPTH_LOG2 = mem_map_pkg::KBD_DEPTH_LOG2_DEF
) (
    input  logic                           clk_pipeline,
    input  logic                           rst,
    input  logic                           ps2_clk,
    input  logic                           ps2_data,
    input  logic [mem_map_pkg::ADDR_W-1:0] instr_addr,
    input  logic                           dmem_read,
    input  logic                           dmem_write,
    input  logic [mem_map_pkg::ADDR_W-1:0] dmem_addr,
    input  logic [3:0]                     dmem_byte_w_en,
    input  logic [mem_map_pkg::DATA_W-1:0] data_from_reg,
    output logic [mem_map_pkg::DATA_W-1:0] instr_data,
    output logic [mem_map_pkg::DATA_W-1:0] dmem_data,
    output logic                           mem_stall,
    output logic                           kb_ready,
    output logic                           kb_overflow,
    output logic [TEXT_ADDR_W-1:0]         text_addr,
    output logic [7:0]                     text_char,
    output logic                           text_wen
);

    import mem_map_pkg::*;

    logic [3:0]        loader_wen;
    logic [DATA_W-1:0] loader_data;
    logic [DATA_W-1:0] loader_instr;
    logic              kbd_read;
    logic              vmem_write;
    logic              text_stall;
    logic [7:0]        keycode;
    logic              code_valid;
    logic [7:0]        rx_code;

    //////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////

    mem_map_decoder u_decoder (
        .dmem_addr      (dmem_addr),
        .dmem_read      (dmem_read),
        .dmem_write     (dmem_write),
        .dmem_byte_w_en (dmem_byte_w_en),
        .instr_addr     (instr_addr),
        .loader_data    (loader_data),
        .loader_instr   (loader_instr),
        .keycode        (keycode),
        .kb_ready       (kb_ready),
        .text_stall     (text_stall),
        .loader_wen     (loader_wen),
        .kbd_read       (kbd_read),
        .vmem_write     (vmem_write),
        .dmem_data      (dmem_data),
        .instr_data     (instr_data),
        .mem_stall      (mem_stall)
    );

    //////////////////////////////////////////////////
    // targets
    //////////////////////////////////////////////////

    // low word bits only, region bits already decoded
    loader_mem #(
        .LOADER_ADDR_W (LOADER_ADDR_W)
    ) u_loader (
        .clk_pipeline (clk_pipeline),
        .data_addr    (dmem_addr[LOADER_ADDR_W-1:0]),
        .data_in      (data_from_reg),
        .wen          (loader_wen),
        .instr_addr   (instr_addr[LOADER_ADDR_W-1:0]),
        .data_out     (loader_data),
        .instr_out    (loader_instr)
    );

    text_write_ctrl #(
        .TEXT_ADDR_W (TEXT_ADDR_W),
        .TEXT_WAIT   (TEXT_WAIT)
    ) u_text (
        .clk_pipeline   (clk_pipeline),
        .rst            (rst),
        .vmem_write     (vmem_write),
        .dmem_addr      (dmem_addr),
        .dmem_byte_w_en (dmem_byte_w_en),
        .data_from_reg  (data_from_reg),
        .text_stall     (text_stall),
        .text_wen       (text_wen),
        .text_addr      (text_addr),
        .text_char      (text_char)
    );

    ps2_receiver u_ps2 (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .code_valid   (code_valid),
        .code         (rx_code)
    );

    // pop on every keyboard read, empty pops are ignored inside
    keycode_fifo #(
        .KBD_DEPTH_LOG2 (KBD_DEPTH_LOG2)
    ) u_kbd_fifo (
        .clk_pipeline (clk_pipeline),
        .rst          (rst),
        .push         (code_valid),
        .push_code    (rx_code),
        .pop          (kbd_read),
        .head_code    (keycode),
        .ready        (kb_ready),
        .overflow     (kb_overflow)
    );

endmodule

//--- source/mem_map_decoder.sv
`timescale 1ns/1ps

module mem_map_decoder (
    input  logic [mem_map_pkg::ADDR_W-1:0] dmem_addr,
    input  logic                           dmem_read,
    input  logic                           dmem_write,
    input  logic [3:0]                     dmem_byte_w_en,
    input  logic [mem_map_pkg::ADDR_W-1:0] instr_addr,
    input  logic [mem_map_pkg::DATA_W-1:0] loader_data,
    input  logic [mem_map_pkg::DATA_W-1:0] loader_instr,
    input  logic [7:0]                     keycode,
    input  logic                           kb_ready,
    input  logic                           text_stall,
    output logic [3:0]                     loader_wen,
    output logic                           kbd_read,
    output logic                           vmem_write,
    output logic [mem_map_pkg::DATA_W-1:0] dmem_data,
    output logic [mem_map_pkg::DATA_W-1:0] instr_data,
    output logic                           mem_stall
);

    import mem_map_pkg::*;

    region_e                    data_region;
    region_e                    instr_region;
    logic [TAG_MSB-TAG_LSB:0]   data_tag;
    logic                       trap_stall;

    assign data_region  = region_e'(dmem_addr[REGION_MSB:REGION_LSB]);
    assign instr_region = region_e'(instr_addr[REGION_MSB:REGION_LSB]);
    assign data_tag     = dmem_addr[TAG_MSB:TAG_LSB];

    //////////////////////////////////////////////////
    // data side steering
    //////////////////////////////////////////////////

    always_comb begin
        loader_wen = 4'b0000;
        kbd_read   = 1'b0;
        vmem_write = 1'b0;
        trap_stall = 1'b0;
        dmem_data  = '0;

        case (data_region)
            REGION_LOADER: begin
                // pipeline lanes are big endian, loader ram is little endian
                if (dmem_write) begin
                    case (dmem_byte_w_en)
                        4'b0001: loader_wen = 4'b1000;
                        4'b0010: loader_wen = 4'b0100;
                        4'b0100: loader_wen = 4'b0010;
                        4'b1000: loader_wen = 4'b0001;
                        default: loader_wen = 4'b1111;
                    endcase
                end
                dmem_data = loader_data;
            end
            REGION_KBD: begin
                kbd_read  = dmem_read;
                dmem_data = {{(DATA_W - 8){1'b0}}, keycode};
            end
            REGION_VMEM: begin
                // write only, reads see zero
                vmem_write = dmem_write;
            end
            REGION_TIMER: begin
                // other tags in this region read zero
                if (data_tag == TRAP_TAG) begin
                    trap_stall = dmem_read | dmem_write;
                end
            end
            REGION_FLASH: begin
                dmem_data = '0;
            end
            default: begin
                // main memory has no backing store here
                dmem_data = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // instruction side
    //////////////////////////////////////////////////

    assign instr_data = (instr_region == REGION_LOADER) ? loader_instr : '0;

    // reading an empty key queue waits for the next key
    assign mem_stall = text_stall | (kbd_read & ~kb_ready) | trap_stall;

endmodule

//--- source/text_write_ctrl.sv
`timescale 1ns/1ps

module text_write_ctrl #(
    parameter int TEXT_ADDR_W = mem_map_pkg::TEXT_ADDR_W_DEF,
    parameter int TEXT_WAIT   = mem_map_pkg::TEXT_WAIT_DEF
) (
    input  logic                           clk_pipeline,
    input  logic                           rst,
    input  logic                           vmem_write,
    input  logic [mem_map_pkg::ADDR_W-1:0] dmem_addr,
    input  logic [3:0]                     dmem_byte_w_en,
    input  logic [mem_map_pkg::DATA_W-1:0] data_from_reg,
    output logic                           text_stall,
    output logic                           text_wen,
    output logic [TEXT_ADDR_W-1:0]         text_addr,
    output logic [7:0]                     text_char
);

    import mem_map_pkg::*;

    localparam int               CNT_W      = $clog2(TEXT_WAIT + 4);
    // counter parks here until the request goes away
    localparam logic [CNT_W-1:0] CNT_MAX    = CNT_W'(TEXT_WAIT + 3);
    localparam logic [CNT_W-1:0] WEN_LAST   = CNT_W'(TEXT_WAIT + 1);
    localparam logic [CNT_W-1:0] STALL_LAST = CNT_W'(TEXT_WAIT + 2);

    logic [CNT_W-1:0] wait_cnt;
    logic [CNT_W-1:0] wait_cnt_next;
    logic [1:0]       lane_offset;

    //////////////////////////////////////////////////
    // wait counter and write strobe
    //////////////////////////////////////////////////

    always_comb begin
        if (!vmem_write) begin
            wait_cnt_next = '0;
        end else if (wait_cnt == CNT_MAX) begin
            wait_cnt_next = wait_cnt;
        end else begin
            wait_cnt_next = wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_pipeline) begin
        if (!rst) begin
            wait_cnt <= '0;
            text_wen <= 1'b0;
        end else begin
            wait_cnt <= wait_cnt_next;
            text_wen <= (wait_cnt_next != '0) && (wait_cnt_next <= WEN_LAST);
        end
    end

    // two spare cycles after the strobe so address and char stay put
    assign text_stall = vmem_write && (wait_cnt <= STALL_LAST);

    //////////////////////////////////////////////////
    // byte address and character
    //////////////////////////////////////////////////

    always_comb begin
        case (dmem_byte_w_en)
            4'b1000: begin
                lane_offset = 2'd0;
                text_char   = data_from_reg[7:0];
            end
            4'b0100: begin
                lane_offset = 2'd1;
                text_char   = data_from_reg[15:8];
            end
            4'b0010: begin
                lane_offset = 2'd2;
                text_char   = data_from_reg[23:16];
            end
            default: begin
                lane_offset = 2'd3;
                text_char   = data_from_reg[31:24];
            end
        endcase
    end

    assign text_addr = {dmem_addr[TEXT_ADDR_W-3:0], lane_offset};

endmodule

//--- tests/mem_interface_patterns.txt
# op word_addr data byte_en expected, all hex
# K: be 1 = bad parity, expected = kb_overflow; P: be 1 = empty queue, data = late key
W 3c000010 11223344 f 00000000
R 3c000010 00000000 0 11223344
W 3c000010 a1b2c3d4 1 00000000
R 3c000010 00000000 0 a1223344
W 3c000010 a1b2c3d4 2 00000000
R 3c000010 00000000 0 a1b23344
W 3c000010 a1b2c3d4 4 00000000
R 3c000010 00000000 0 a1b2c344
W 3c000010 a1b2c3d4 8 00000000
R 3c000010 00000000 0 a1b2c3d4
W 3c000011 55667788 3 00000000
R 3c000011 00000000 0 55667788
I 3c000010 00000000 0 a1b2c3d4
I 3c000011 00000000 0 55667788
I 00000010 00000000 0 00000000
V 30000123 41424344 8 00048c44
V 30000123 41424344 4 00048d43
V 30000123 41424344 2 00048e42
V 30000123 41424344 1 00048f41
K 00000000 0000001c 0 00000000
K 00000000 00000032 0 00000000
K 00000000 0000005a 1 00000000
K 00000000 00000021 0 00000000
P 38000000 00000000 0 0000001c
P 38000000 00000000 0 00000032
P 38000000 00000000 0 00000021
P 38000000 00000029 1 00000029
K 00000000 00000001 0 00000000
K 00000000 00000002 0 00000000
K 00000000 00000003 0 00000000
K 00000000 00000004 0 00000000
K 00000000 00000005 0 00000000
K 00000000 00000006 0 00000000
K 00000000 00000007 0 00000000
K 00000000 00000008 0 00000000
K 00000000 00000009 0 00000001
P 38000000 00000000 0 00000001
P 38000000 00000000 0 00000002
P 38000000 00000000 0 00000003
P 38000000 00000000 0 00000004
P 38000000 00000000 0 00000005
P 38000000 00000000 0 00000006
P 38000000 00000000 0 00000007
P 38000000 00000000 0 00000008
T 37740000 00000000 0 00000001
T 34480000 00000000 0 00000000
Z 2c000040 00000000 0 00000000
Z 00000100 00000000 0 00000000
Z 30000010 00000000 0 00000000

//--- tests/mem_interface_tb.sv
`timescale 1ns/1ps

module mem_interface_tb;

    import mem_map_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int QUARTER      = CLK_PERIOD / 4;
    localparam int HALF_BIT     = 4;
    localparam int WEN_CYCLES   = 6;
    localparam int STALL_CYCLES = 8;
    localparam int STALL_LIMIT  = 150;
    localparam int TRAP_HOLD    = 5;

    logic                       clk_pipeline;
    logic                       rst;
    logic                       ps2_clk;
    logic                       ps2_data;
    logic [ADDR_W-1:0]          instr_addr;
    logic                       dmem_read;
    logic                       dmem_write;
    logic [ADDR_W-1:0]          dmem_addr;
    logic [3:0]                 dmem_byte_w_en;
    logic [DATA_W-1:0]          data_from_reg;
    logic [DATA_W-1:0]          instr_data;
    logic [DATA_W-1:0]          dmem_data;
    logic                       mem_stall;
    logic                       kb_ready;
    logic                       kb_overflow;
    logic [TEXT_ADDR_W_DEF-1:0] text_addr;
    logic [7:0]                 text_char;
    logic                       text_wen;

    byte               op_q[$];
    logic [ADDR_W-1:0] addr_q[$];
    logic [DATA_W-1:0] data_q[$];
    logic [3:0]        be_q[$];
    logic [DATA_W-1:0] exp_q[$];
    int                value_errors = 0;
    int                other_errors = 0;

    mem_interface_top dut (.*);

    always #(CLK_PERIOD / 2) clk_pipeline = ~clk_pipeline;

    //////////////////////////////////////////////////
    // checks and pattern file
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            value_errors++;
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          status;
        string       line;
        byte         op;
        logic [31:0] f_addr, f_data, f_be, f_exp;
        fd = $fopen("tests/mem_interface_patterns.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            status = $fgets(line, fd);
            if (status > 0 && line.len() > 1 && line[0] != "#") begin
                status = $sscanf(line, "%c %h %h %h %h", op, f_addr, f_data, f_be, f_exp);
                if (status == 5) begin
                    op_q.push_back(op);
                    addr_q.push_back(f_addr[ADDR_W-1:0]);
                    data_q.push_back(f_data);
                    be_q.push_back(f_be[3:0]);
                    exp_q.push_back(f_exp);
                end
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////
    // bus and keyboard drivers
    //////////////////////////////////////////////////

    // start bit, 8 data bits lsb first, odd parity, stop bit
    task automatic send_ps2_frame(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
        @(negedge clk_pipeline);
        for (int i = 0; i < 11; i++) begin
            ps2_data = frame[i];
            repeat (HALF_BIT) @(negedge clk_pipeline);
            ps2_clk = 1'b0;
            repeat (HALF_BIT) @(negedge clk_pipeline);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        repeat (HALF_BIT) @(negedge clk_pipeline);
    endtask

    task automatic loader_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                                 input logic [3:0] be, input logic write,
                                 input logic [DATA_W-1:0] expected);
        @(negedge clk_pipeline);
        dmem_addr      = addr;
        data_from_reg  = data;
        dmem_byte_w_en = be;
        dmem_write     = write;
        dmem_read      = ~write;
        #(QUARTER);
        check_value("mem_stall", mem_stall, 0);
        @(negedge clk_pipeline);
        dmem_write = 1'b0;
        if (!write) begin
            // registered read port, word shows one cycle later
            #(QUARTER);
            check_value("dmem_data", dmem_data, expected);
            @(negedge clk_pipeline);
            dmem_read = 1'b0;
        end
        dmem_addr = '0;
    endtask

    task automatic fetch(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] expected);
        @(negedge clk_pipeline);
        instr_addr = addr;
        @(negedge clk_pipeline);
        #(QUARTER);
        check_value("instr_data", instr_data, expected);
    endtask

    task automatic text_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [3:0] be, input logic [DATA_W-1:0] expected);
        int stall_cycles;
        int wen_cycles;
        stall_cycles = 0;
        wen_cycles   = 0;
        @(negedge clk_pipeline);
        dmem_addr      = addr;
        data_from_reg  = data;
        dmem_byte_w_en = be;
        dmem_write     = 1'b1;
        for (int cyc = 0; cyc < STALL_CYCLES + 3; cyc++) begin
            #(QUARTER);
            stall_cycles += mem_stall;
            if (text_wen) begin
                wen_cycles++;
                check_value("text_addr", text_addr, expected[22:8]);
                check_value("text_char", text_char, expected[7:0]);
            end
            if (cyc == STALL_CYCLES + 2) begin
                check_value("mem_stall", mem_stall, 0);
            end
            @(negedge clk_pipeline);
        end
        dmem_write = 1'b0;
        dmem_addr  = '0;
        check_value("text_wen cycles", wen_cycles, WEN_CYCLES);
        check_value("mem_stall cycles", stall_cycles, STALL_CYCLES);
    endtask

    // trap tag holds the stall, everything else reads zero at once
    task automatic hold_read(input logic [ADDR_W-1:0] addr, input logic stall_exp,
                             input logic [DATA_W-1:0] data_exp);
        @(negedge clk_pipeline);
        dmem_addr = addr;
        dmem_read = 1'b1;
        for (int i = 0; i < TRAP_HOLD; i++) begin
            #(QUARTER);
            check_value("mem_stall", mem_stall, stall_exp);
            check_value("dmem_data", dmem_data, data_exp);
            @(negedge clk_pipeline);
        end
        dmem_read = 1'b0;
        dmem_addr = '0;
        #(QUARTER);
        check_value("mem_stall", mem_stall, 0);
    endtask

    task automatic keyboard_read(input logic [ADDR_W-1:0] addr, input logic [7:0] late_code,
                                 input logic expect_empty, input logic [DATA_W-1:0] expected);
        int waited;
        waited = 0;
        @(negedge clk_pipeline);
        dmem_addr = addr;
        dmem_read = 1'b1;
        #(QUARTER);
        check_value("kb_ready", kb_ready, !expect_empty);
        if (expect_empty) begin
            check_value("mem_stall", mem_stall, 1);
        end
        fork
            begin
                if (expect_empty) begin
                    send_ps2_frame(late_code, 1'b0);
                end
            end
            begin
                while (mem_stall && waited < STALL_LIMIT) begin
                    @(negedge clk_pipeline);
                    #(QUARTER);
                    waited++;
                end
                if (mem_stall) begin
                    $display("keyboard read at %0t ns still stalled after %0d cycles",
                             $time, waited);
                    other_errors++;
                end else begin
                    check_value("dmem_data", dmem_data, expected);
                end
                // the pop happens on the edge in between
                @(negedge clk_pipeline);
                dmem_read = 1'b0;
                dmem_addr = '0;
            end
        join
        #(QUARTER);
        check_value("kb_overflow", kb_overflow, 0);
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        clk_pipeline   = 1'b0;
        rst            = 1'b0;
        ps2_clk        = 1'b1;
        ps2_data       = 1'b1;
        instr_addr     = '0;
        dmem_read      = 1'b0;
        dmem_write     = 1'b0;
        dmem_addr      = '0;
        dmem_byte_w_en = 4'b0000;
        data_from_reg  = '0;
        load_patterns();
        if (op_q.size() == 0) begin
            $display("no patterns could be read from tests/mem_interface_patterns.txt");
            $display("sim failed");
            $finish;
        end
        fork
            begin
                #(op_q.size() * 200 * CLK_PERIOD);
                $display("watchdog: run did not finish within %0d cycles",
                         op_q.size() * 200);
                $display("sim failed");
                $finish;
            end
        join_none
        repeat (10) @(negedge clk_pipeline);
        rst = 1'b1;
        foreach (op_q[i]) begin
            case (op_q[i])
                "W": loader_access(addr_q[i], data_q[i], be_q[i], 1'b1, exp_q[i]);
                "R": loader_access(addr_q[i], data_q[i], be_q[i], 1'b0, exp_q[i]);
                "I": fetch(addr_q[i], exp_q[i]);
                "V": text_write(addr_q[i], data_q[i], be_q[i], exp_q[i]);
                "K": begin
                    send_ps2_frame(data_q[i][7:0], be_q[i] != 4'h0);
                    #(QUARTER);
                    check_value("kb_overflow", kb_overflow, exp_q[i]);
                end
                "P": keyboard_read(addr_q[i], data_q[i][7:0], be_q[i] != 4'h0, exp_q[i]);
                "T": hold_read(addr_q[i], exp_q[i][0], '0);
                "Z": hold_read(addr_q[i], 1'b0, exp_q[i]);
                default: begin
                    $display("pattern %0d has an unknown operation", i);
                    other_errors++;
                end
            endcase
        end
        repeat (4) @(negedge clk_pipeline);
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
